/* rtl/dcache_pkg.sv */
`default_nettype none

package dcache_pkg;

    // bus and line geometry
    localparam int ADDR_W     = 32;
    localparam int WORD_W     = 32;
    localparam int LINE_WORDS = 4;
    localparam int LINE_W     = WORD_W * LINE_WORDS;
    localparam int OFFSET_W   = $clog2(LINE_W / 8);

    // defaults picked up by the top level
    localparam int DEF_NWAY = 2;
    localparam int DEF_NSET = 64;

    typedef logic [ADDR_W-1:0]   addr_t;
    typedef logic [WORD_W-1:0]   word_t;
    // all zero means a load
    typedef logic [WORD_W/8-1:0] strb_t;
    // word k sits at bits 32k upward
    typedef logic [LINE_W-1:0]   line_t;

    typedef struct packed {
        addr_t addr;
        strb_t wstrb;
        word_t wdata;
    } cpu_req_t;

    // one full line towards memory
    typedef struct packed {
        addr_t addr;
        line_t data;
    } mem_wr_t;

    typedef enum logic [2:0] {
        IDLE,
        WB_REQ,
        WB_WAIT,
        REFILL_REQ,
        REFILL_WAIT
    } ctrl_state_e;

endpackage

`default_nettype wire

/* rtl/dcache_array.sv */
`timescale 1ns/1ps
`default_nettype none

// one way of storage, used for both tag entries and data lines
module dcache_array #(
    parameter int  DEPTH   = 64,
    parameter type entry_t = logic
) (
    input  wire logic                     clk,

    // read port, registered output
    input  wire logic                     rd_en_i,
    input  wire logic [$clog2(DEPTH)-1:0] rd_idx_i,
    output entry_t                        rd_data_o,

    // write port, whole entry at once
    input  wire logic                     wr_en_i,
    input  wire logic [$clog2(DEPTH)-1:0] wr_idx_i,
    input  entry_t                        wr_data_i
);

    entry_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_idx_i] <= wr_data_i;
        end
    end

    // output holds until the next enabled read
    always_ff @(posedge clk) begin
        if (rd_en_i) begin
            rd_data_o <= mem[rd_idx_i];
        end
    end

endmodule

`default_nettype wire

/* rtl/dcache_lfsr.sv */
`timescale 1ns/1ps
`default_nettype none

// fibonacci lfsr, steps every cycle
module dcache_lfsr #(
    parameter int WIDTH = 16
) (
    input  wire logic             clk,
    input  wire logic             rst,
    output logic      [WIDTH-1:0] value_o
);

    // maximal length taps for the common widths, 16 bit otherwise
    localparam logic [WIDTH-1:0] TAPS = (WIDTH == 8)  ? WIDTH'('hB8) :
                                        (WIDTH == 32) ? WIDTH'('h80200003) :
                                                        WIDTH'('hB400);
    localparam logic [WIDTH-1:0] SEED = WIDTH'('hACE1);

    logic feedback;

    assign feedback = ^(value_o & TAPS);

    always_ff @(posedge clk) begin
        if (rst) begin
            value_o <= SEED;
        end else begin
            value_o <= {value_o[WIDTH-2:0], feedback};
        end
    end

endmodule

`default_nettype wire

/* rtl/dcache_lookup.sv */
`timescale 1ns/1ps
`default_nettype none

// lookup stage: request register, tag compare and hit line select
module dcache_lookup #(
    parameter int  NWAY        = 2,
    parameter int  NSET        = 64,
    parameter type tag_entry_t = logic
) (
    input  wire logic                                  clk,
    input  wire logic                                  rst,

    input  wire logic                                  accept_i,
    input  wire logic                                  hold_i,
    input  dcache_pkg::cpu_req_t                       req_i,

    // array outputs, one entry per way
    input  tag_entry_t            [NWAY-1:0]           tags_i,
    input  dcache_pkg::line_t     [NWAY-1:0]           lines_i,

    output logic                                       valid_o,
    output dcache_pkg::cpu_req_t                       req_o,
    output logic                                       hit_o,
    output logic [(NWAY > 1 ? $clog2(NWAY) : 1)-1:0]   hit_way_o,
    output dcache_pkg::line_t                          hit_line_o,
    output tag_entry_t            [NWAY-1:0]           tags_o
);

    localparam int WAY_W = (NWAY > 1) ? $clog2(NWAY) : 1;
    localparam int TAG_W = dcache_pkg::ADDR_W - $clog2(NSET) - dcache_pkg::OFFSET_W;

    logic                                held_q;
    tag_entry_t        [NWAY-1:0]        snap_tags;
    dcache_pkg::line_t [NWAY-1:0]        snap_lines;
    dcache_pkg::line_t [NWAY-1:0]        cur_lines;
    logic              [TAG_W-1:0]       req_tag;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_o <= 1'b0;
            held_q  <= 1'b0;
        end else begin
            held_q <= hold_i;
            if (!hold_i) begin
                valid_o <= accept_i;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!hold_i && accept_i) begin
            req_o <= req_i;
        end
        // keep the victim contents across the miss
        if (hold_i && !held_q) begin
            snap_tags  <= tags_i;
            snap_lines <= lines_i;
        end
    end

    assign tags_o    = held_q ? snap_tags : tags_i;
    assign cur_lines = held_q ? snap_lines : lines_i;
    assign req_tag   = req_o.addr[dcache_pkg::ADDR_W-1 -: TAG_W];

    // at most one way can match a given tag
    always_comb begin
        hit_o      = 1'b0;
        hit_way_o  = '0;
        hit_line_o = cur_lines[0];
        for (int w = 0; w < NWAY; w++) begin
            if (tags_o[w].valid && tags_o[w].tag == req_tag) begin
                hit_o      = 1'b1;
                hit_way_o  = WAY_W'(w);
                hit_line_o = cur_lines[w];
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/dcache_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

// miss handling, store merge, array writes and cpu response
module dcache_ctrl #(
    parameter int  NWAY        = 2,
    parameter int  NSET        = 64,
    parameter type tag_entry_t = logic
) (
    input  wire logic                                 clk,
    input  wire logic                                 rst,
    input  wire logic                                 req_valid_i,

    // from the lookup stage
    input  wire logic                                 valid_i,
    input  dcache_pkg::cpu_req_t                      req_i,
    input  wire logic                                 hit_i,
    input  wire logic [(NWAY > 1 ? $clog2(NWAY) : 1)-1:0] hit_way_i,
    input  dcache_pkg::line_t                         hit_line_i,
    input  tag_entry_t        [NWAY-1:0]              tags_i,
    input  dcache_pkg::line_t [NWAY-1:0]              lines_i,
    input  wire logic [(NWAY > 1 ? $clog2(NWAY) : 1)-1:0] victim_i,

    // memory side
    input  wire logic                                 mem_rd_valid_i,
    input  dcache_pkg::line_t                         mem_rd_data_i,
    input  wire logic                                 mem_wr_done_i,

    output logic                                      ready_o,
    output logic                                      accept_o,
    output logic                                      hold_o,

    // array write port
    output logic              [NWAY-1:0]              tag_we_o,
    output logic              [NWAY-1:0]              data_we_o,
    output logic              [$clog2(NSET)-1:0]      wr_idx_o,
    output tag_entry_t                                tag_wdata_o,
    output dcache_pkg::line_t                         line_wdata_o,

    output logic                                      mem_rd_req_o,
    output dcache_pkg::addr_t                         mem_rd_addr_o,
    output logic                                      mem_wr_req_o,
    output dcache_pkg::mem_wr_t                       mem_wr_o,

    output logic                                      resp_valid_o,
    output dcache_pkg::word_t                         rdata_o
);

    localparam int WAY_W  = (NWAY > 1) ? $clog2(NWAY) : 1;
    localparam int IDX_W  = $clog2(NSET);
    localparam int TAG_W  = dcache_pkg::ADDR_W - IDX_W - dcache_pkg::OFFSET_W;
    localparam int BOFF_W = $clog2(dcache_pkg::WORD_W / 8);
    localparam int SEL_W  = $clog2(dcache_pkg::LINE_WORDS);

    dcache_pkg::ctrl_state_e state, next_state;
    logic [WAY_W-1:0]  victim_q;
    logic              init_busy;
    logic [IDX_W-1:0]  init_cnt;
    logic              is_store;
    logic              miss;
    logic              refill_done;
    logic [IDX_W-1:0]  idx;
    logic [TAG_W-1:0]  req_tag;
    logic [SEL_W-1:0]  word_sel;
    tag_entry_t        wb_entry;
    dcache_pkg::line_t base_line;

    // masked bytes of the store into the addressed word
    function automatic dcache_pkg::line_t merge_store(input dcache_pkg::line_t base,
                                                      input dcache_pkg::cpu_req_t req,
                                                      input logic [SEL_W-1:0] sel);
        dcache_pkg::line_t merged;
        merged = base;
        for (int b = 0; b < dcache_pkg::WORD_W / 8; b++) begin
            if (req.wstrb[b]) begin
                merged[sel*dcache_pkg::WORD_W + b*8 +: 8] = req.wdata[b*8 +: 8];
            end
        end
        return merged;
    endfunction

    assign is_store    = |req_i.wstrb;
    assign idx         = req_i.addr[dcache_pkg::OFFSET_W +: IDX_W];
    assign req_tag     = req_i.addr[dcache_pkg::ADDR_W-1 -: TAG_W];
    assign word_sel    = req_i.addr[BOFF_W +: SEL_W];
    assign miss        = (state == dcache_pkg::IDLE) && valid_i && !hit_i;
    assign refill_done = (state == dcache_pkg::REFILL_WAIT) && mem_rd_valid_i;
    assign wb_entry    = tags_i[victim_q];

    // a store hit leaves one bubble so the next read sees the new line
    assign ready_o  = !init_busy && (state == dcache_pkg::IDLE) &&
                      !(valid_i && (is_store || !hit_i));
    assign accept_o = req_valid_i && ready_o;
    // lookup entry retires together with the refill response
    assign hold_o   = (state != dcache_pkg::IDLE) && !refill_done;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= dcache_pkg::IDLE;
            victim_q  <= '0;
            init_busy <= 1'b1;
            init_cnt  <= '0;
        end else begin
            state <= next_state;
            if (miss) begin
                victim_q <= victim_i;
            end
            // invalidate walk over every set
            if (init_busy) begin
                init_cnt <= init_cnt + 1'b1;
                if (init_cnt == IDX_W'(NSET - 1)) begin
                    init_busy <= 1'b0;
                end
            end
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            dcache_pkg::IDLE: begin
                if (miss) begin
                    if (tags_i[victim_i].valid && tags_i[victim_i].dirty) begin
                        next_state = dcache_pkg::WB_REQ;
                    end else begin
                        next_state = dcache_pkg::REFILL_REQ;
                    end
                end
            end
            dcache_pkg::WB_REQ: next_state = dcache_pkg::WB_WAIT;
            dcache_pkg::WB_WAIT: begin
                if (mem_wr_done_i) begin
                    next_state = dcache_pkg::REFILL_REQ;
                end
            end
            dcache_pkg::REFILL_REQ: next_state = dcache_pkg::REFILL_WAIT;
            dcache_pkg::REFILL_WAIT: begin
                if (mem_rd_valid_i) begin
                    next_state = dcache_pkg::IDLE;
                end
            end
            default: next_state = dcache_pkg::IDLE;
        endcase
    end

    assign base_line    = (state == dcache_pkg::REFILL_WAIT) ? mem_rd_data_i : hit_line_i;
    assign line_wdata_o = merge_store(base_line, req_i, word_sel);

    always_comb begin
        tag_we_o    = '0;
        data_we_o   = '0;
        wr_idx_o    = idx;
        tag_wdata_o = '0;
        if (init_busy) begin
            tag_we_o = '1;
            wr_idx_o = init_cnt;
        end else if (state == dcache_pkg::IDLE && valid_i && hit_i && is_store) begin
            tag_we_o[hit_way_i]  = 1'b1;
            data_we_o[hit_way_i] = 1'b1;
            tag_wdata_o.dirty    = 1'b1;
            tag_wdata_o.valid    = 1'b1;
            tag_wdata_o.tag      = req_tag;
        end else if (refill_done) begin
            // clean for a load, dirty when a store was merged in
            tag_we_o[victim_q]  = 1'b1;
            data_we_o[victim_q] = 1'b1;
            tag_wdata_o.dirty   = is_store;
            tag_wdata_o.valid   = 1'b1;
            tag_wdata_o.tag     = req_tag;
        end
    end

    assign mem_rd_req_o  = (state == dcache_pkg::REFILL_REQ);
    assign mem_rd_addr_o = {req_i.addr[dcache_pkg::ADDR_W-1:dcache_pkg::OFFSET_W],
                            {dcache_pkg::OFFSET_W{1'b0}}};

    // victim line goes out before its refill
    assign mem_wr_req_o  = (state == dcache_pkg::WB_REQ);
    assign mem_wr_o.addr = {wb_entry.tag, idx, {dcache_pkg::OFFSET_W{1'b0}}};
    assign mem_wr_o.data = lines_i[victim_q];

    assign resp_valid_o = ((state == dcache_pkg::IDLE) && valid_i && hit_i) || refill_done;
    assign rdata_o      = base_line[word_sel*dcache_pkg::WORD_W +: dcache_pkg::WORD_W];

endmodule

`default_nettype wire

/* rtl/dcache_top.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_top #(
    parameter int NWAY = dcache_pkg::DEF_NWAY,
    parameter int NSET = dcache_pkg::DEF_NSET
) (
    input  wire logic            clk,
    input  wire logic            rst,

    // cpu side
    input  wire logic            req_valid_i,
    input  dcache_pkg::cpu_req_t req_i,
    output logic                 ready_o,
    output logic                 resp_valid_o,
    output dcache_pkg::word_t    rdata_o,

    // memory side
    output logic                 mem_rd_req_o,
    output dcache_pkg::addr_t    mem_rd_addr_o,
    input  wire logic            mem_rd_valid_i,
    input  dcache_pkg::line_t    mem_rd_data_i,
    output logic                 mem_wr_req_o,
    output dcache_pkg::mem_wr_t  mem_wr_o,
    input  wire logic            mem_wr_done_i
);

    localparam int IDX_W  = $clog2(NSET);
    localparam int TAG_W  = dcache_pkg::ADDR_W - IDX_W - dcache_pkg::OFFSET_W;
    localparam int WAY_W  = (NWAY > 1) ? $clog2(NWAY) : 1;
    localparam int LFSR_W = 16;

    typedef struct packed {
        logic             dirty;
        logic             valid;
        logic [TAG_W-1:0] tag;
    } tag_entry_t;

    logic                              accept;
    logic                              hold;
    logic              [IDX_W-1:0]     rd_idx;
    logic              [IDX_W-1:0]     wr_idx;
    logic              [NWAY-1:0]      tag_we;
    logic              [NWAY-1:0]      data_we;
    tag_entry_t                        tag_wdata;
    dcache_pkg::line_t                 line_wdata;
    tag_entry_t        [NWAY-1:0]      tag_rdata;
    dcache_pkg::line_t [NWAY-1:0]      line_rdata;
    logic                              lk_valid;
    dcache_pkg::cpu_req_t              lk_req;
    logic                              lk_hit;
    logic              [WAY_W-1:0]     lk_hit_way;
    dcache_pkg::line_t                 lk_hit_line;
    tag_entry_t        [NWAY-1:0]      lk_tags;
    logic              [LFSR_W-1:0]    lfsr_value;
    logic              [WAY_W-1:0]     victim;

    assign rd_idx = req_i.addr[dcache_pkg::OFFSET_W +: IDX_W];
    assign victim = (NWAY > 1) ? lfsr_value[WAY_W-1:0] : '0;

    for (genvar w = 0; w < NWAY; w++) begin : g_way
        dcache_array #(
            .DEPTH   (NSET),
            .entry_t (tag_entry_t)
        ) u_tag (
            .clk       (clk),
            .rd_en_i   (accept),
            .rd_idx_i  (rd_idx),
            .rd_data_o (tag_rdata[w]),
            .wr_en_i   (tag_we[w]),
            .wr_idx_i  (wr_idx),
            .wr_data_i (tag_wdata)
        );

        dcache_array #(
            .DEPTH   (NSET),
            .entry_t (dcache_pkg::line_t)
        ) u_data (
            .clk       (clk),
            .rd_en_i   (accept),
            .rd_idx_i  (rd_idx),
            .rd_data_o (line_rdata[w]),
            .wr_en_i   (data_we[w]),
            .wr_idx_i  (wr_idx),
            .wr_data_i (line_wdata)
        );
    end

    dcache_lookup #(
        .NWAY        (NWAY),
        .NSET        (NSET),
        .tag_entry_t (tag_entry_t)
    ) u_lookup (
        .clk        (clk),
        .rst        (rst),
        .accept_i   (accept),
        .hold_i     (hold),
        .req_i      (req_i),
        .tags_i     (tag_rdata),
        .lines_i    (line_rdata),
        .valid_o    (lk_valid),
        .req_o      (lk_req),
        .hit_o      (lk_hit),
        .hit_way_o  (lk_hit_way),
        .hit_line_o (lk_hit_line),
        .tags_o     (lk_tags)
    );

    dcache_ctrl #(
        .NWAY        (NWAY),
        .NSET        (NSET),
        .tag_entry_t (tag_entry_t)
    ) u_ctrl (
        .clk            (clk),
        .rst            (rst),
        .req_valid_i    (req_valid_i),
        .valid_i        (lk_valid),
        .req_i          (lk_req),
        .hit_i          (lk_hit),
        .hit_way_i      (lk_hit_way),
        .hit_line_i     (lk_hit_line),
        .tags_i         (lk_tags),
        .lines_i        (line_rdata),
        .victim_i       (victim),
        .mem_rd_valid_i (mem_rd_valid_i),
        .mem_rd_data_i  (mem_rd_data_i),
        .mem_wr_done_i  (mem_wr_done_i),
        .ready_o        (ready_o),
        .accept_o       (accept),
        .hold_o         (hold),
        .tag_we_o       (tag_we),
        .data_we_o      (data_we),
        .wr_idx_o       (wr_idx),
        .tag_wdata_o    (tag_wdata),
        .line_wdata_o   (line_wdata),
        .mem_rd_req_o   (mem_rd_req_o),
        .mem_rd_addr_o  (mem_rd_addr_o),
        .mem_wr_req_o   (mem_wr_req_o),
        .mem_wr_o       (mem_wr_o),
        .resp_valid_o   (resp_valid_o),
        .rdata_o        (rdata_o)
    );

    dcache_lfsr #(
        .WIDTH (LFSR_W)
    ) u_lfsr (
        .clk     (clk),
        .rst     (rst),
        .value_o (lfsr_value)
    );

endmodule

`default_nettype wire

/* verification/tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

// free-running clock plus a reset held for a fixed number of cycles
module tb_clock_gen #(
    parameter int PERIOD     = 40,
    parameter int RST_CYCLES = 4
) (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;
    end

    initial begin
        rst_o = 1'b1;
        repeat (RST_CYCLES) @(posedge clk_o);
        rst_o <= 1'b0;
    end

endmodule

`default_nettype wire

/* verification/dcache_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

// protocol properties on the cache top-level ports
module dcache_assertions (
    input wire logic clk,
    input wire logic rst,
    input wire logic req_valid_i,
    input wire logic ready_o,
    input wire logic resp_valid_o,
    input wire logic mem_rd_req_o,
    input wire logic mem_wr_req_o,
    input wire logic mem_rd_valid_i
);

    logic rd_open;
    logic accepted;

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_open  <= 1'b0;
            accepted <= 1'b0;
        end else begin
            if (mem_rd_req_o) begin
                rd_open <= 1'b1;
            end else if (mem_rd_valid_i) begin
                rd_open <= 1'b0;
            end
            if (req_valid_i && ready_o) begin
                accepted <= 1'b1;
            end
        end
    end

    a_one_mem_req: assert property (@(posedge clk) disable iff (rst)
        !(mem_rd_req_o && mem_wr_req_o))
        else $error("read and write request pulsed in the same cycle");

    // one refill outstanding at a time
    a_single_read: assert property (@(posedge clk) disable iff (rst)
        mem_rd_req_o |-> !rd_open)
        else $error("second read request before the refill data came back");

    a_resp_after_accept: assert property (@(posedge clk) disable iff (rst)
        resp_valid_o |-> accepted)
        else $error("response without any accepted request");

endmodule

bind dcache_top dcache_assertions i_assertions (
    .clk            (clk),
    .rst            (rst),
    .req_valid_i    (req_valid_i),
    .ready_o        (ready_o),
    .resp_valid_o   (resp_valid_o),
    .mem_rd_req_o   (mem_rd_req_o),
    .mem_wr_req_o   (mem_wr_req_o),
    .mem_rd_valid_i (mem_rd_valid_i)
);

`default_nettype wire

/* verification/tb_dcache.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_dcache;

    localparam int NWAY    = dcache_pkg::DEF_NWAY;
    localparam int NSET    = dcache_pkg::DEF_NSET;
    localparam int TIMEOUT = 200;
    localparam int SET_LSB = dcache_pkg::OFFSET_W;
    localparam int TAG_LSB = dcache_pkg::OFFSET_W + $clog2(NSET);

    logic                 clk;
    logic                 rst;
    logic                 req_valid = 1'b0;
    dcache_pkg::cpu_req_t req       = '0;
    logic                 ready;
    logic                 resp_valid;
    dcache_pkg::word_t    rdata;
    logic                 mem_rd_req;
    dcache_pkg::addr_t    mem_rd_addr;
    logic                 mem_rd_valid = 1'b0;
    dcache_pkg::line_t    mem_rd_data  = '0;
    logic                 mem_wr_req;
    dcache_pkg::mem_wr_t  mem_wr;
    logic                 mem_wr_done  = 1'b0;

    // backing memory and the cpu view, both sparse byte maps
    logic [7:0]        mem_bytes [dcache_pkg::addr_t];
    logic [7:0]        shadow    [dcache_pkg::addr_t];
    string             cur_test = "reset";
    int                rd_count = 0;
    int                wr_count = 0;
    dcache_pkg::addr_t last_rd_addr;
    bit                rd_pending = 0;
    int                rd_wait;
    dcache_pkg::addr_t rd_addr;
    bit                wr_pending = 0;
    int                wr_wait;
    bit                check_wb_set = 0;
    int                wb_set;

    tb_clock_gen #(.PERIOD(40), .RST_CYCLES(4)) u_clk (.clk_o(clk), .rst_o(rst));

    dcache_top #(
        .NWAY (NWAY),
        .NSET (NSET)
    ) i_dut (
        .clk            (clk),
        .rst            (rst),
        .req_valid_i    (req_valid),
        .req_i          (req),
        .ready_o        (ready),
        .resp_valid_o   (resp_valid),
        .rdata_o        (rdata),
        .mem_rd_req_o   (mem_rd_req),
        .mem_rd_addr_o  (mem_rd_addr),
        .mem_rd_valid_i (mem_rd_valid),
        .mem_rd_data_i  (mem_rd_data),
        .mem_wr_req_o   (mem_wr_req),
        .mem_wr_o       (mem_wr),
        .mem_wr_done_i  (mem_wr_done)
    );

    task automatic stop_run();
        $display("sim failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic report_failure(input string msg);
        $display("ERROR in %s: %s", cur_test, msg);
        stop_run();
    endtask

    task automatic check_word(input string test, input dcache_pkg::word_t exp,
                              input dcache_pkg::word_t act);
        if (exp !== act) begin
            $display("CHECK FAILED %s expected %h actual %h", test, exp, act);
            stop_run();
        end
    endtask

    task automatic check_line(input string test, input dcache_pkg::line_t exp,
                              input dcache_pkg::line_t act);
        if (exp !== act) begin
            $display("CHECK FAILED %s expected %h actual %h", test, exp, act);
            stop_run();
        end
    endtask

    task automatic check_addr(input string test, input dcache_pkg::addr_t exp,
                              input dcache_pkg::addr_t act);
        if (exp !== act) begin
            $display("CHECK FAILED %s expected %h actual %h", test, exp, act);
            stop_run();
        end
    endtask

    // fill pattern mixes every address bit
    function automatic logic [7:0] fill_byte(input dcache_pkg::addr_t a);
        logic [31:0] h;
        h = (a ^ 32'h2545f491) * 32'h9e3779b1;
        return h[31:24] ^ h[7:0];
    endfunction

    function automatic logic [7:0] shadow_byte(input dcache_pkg::addr_t a);
        return shadow.exists(a) ? shadow[a] : fill_byte(a);
    endfunction

    function automatic logic [7:0] mem_byte(input dcache_pkg::addr_t a);
        return mem_bytes.exists(a) ? mem_bytes[a] : fill_byte(a);
    endfunction

    function automatic dcache_pkg::word_t shadow_word(input dcache_pkg::addr_t a);
        dcache_pkg::word_t w;
        for (int b = 0; b < 4; b++) begin
            w[b*8 +: 8] = shadow_byte({a[31:2], 2'b00} + b);
        end
        return w;
    endfunction

    function automatic dcache_pkg::line_t shadow_line(input dcache_pkg::addr_t a);
        dcache_pkg::line_t l;
        for (int k = 0; k < 16; k++) begin
            l[k*8 +: 8] = shadow_byte({a[31:4], 4'h0} + k);
        end
        return l;
    endfunction

    function automatic dcache_pkg::line_t mem_line(input dcache_pkg::addr_t a);
        dcache_pkg::line_t l;
        for (int k = 0; k < 16; k++) begin
            l[k*8 +: 8] = mem_byte({a[31:4], 4'h0} + k);
        end
        return l;
    endfunction

    function automatic dcache_pkg::addr_t make_addr(input int tag, input int set,
                                                    input int word);
        return (dcache_pkg::addr_t'(tag) << TAG_LSB) | (dcache_pkg::addr_t'(set) << SET_LSB)
               | (dcache_pkg::addr_t'(word) << 2);
    endfunction

    // memory model answering both pulse ports after a random delay
    always @(posedge clk) begin
        mem_rd_valid <= 1'b0;
        mem_wr_done  <= 1'b0;
        if (!rst) begin
            if (mem_rd_req) begin
                rd_count++;
                last_rd_addr = mem_rd_addr;
                rd_addr      = mem_rd_addr;
                rd_pending   = 1;
                rd_wait      = $urandom_range(1, 6);
            end else if (rd_pending) begin
                rd_wait--;
                if (rd_wait <= 0) begin
                    mem_rd_valid <= 1'b1;
                    mem_rd_data  <= mem_line(rd_addr);
                    rd_pending = 0;
                end
            end
            if (mem_wr_req) begin
                wr_count++;
                check_addr(cur_test, mem_wr.addr & ~32'hf, mem_wr.addr);
                if (check_wb_set) begin
                    check_addr(cur_test,
                               (mem_wr.addr & ~(dcache_pkg::addr_t'(NSET - 1) << SET_LSB))
                               | (dcache_pkg::addr_t'(wb_set) << SET_LSB), mem_wr.addr);
                end
                check_line(cur_test, shadow_line(mem_wr.addr), mem_wr.data);
                for (int k = 0; k < 16; k++) begin
                    mem_bytes[mem_wr.addr + k] = mem_wr.data[k*8 +: 8];
                end
                wr_pending = 1;
                wr_wait    = $urandom_range(1, 6);
            end else if (wr_pending) begin
                wr_wait--;
                if (wr_wait <= 0) begin
                    mem_wr_done <= 1'b1;
                    wr_pending = 0;
                end
            end
        end
    end

    // one request through the cache, latency counted from the accept edge
    task automatic access(input dcache_pkg::addr_t addr, input dcache_pkg::strb_t strb,
                          input dcache_pkg::word_t wdata, output dcache_pkg::word_t data,
                          output int lat);
        dcache_pkg::cpu_req_t r;
        int                   waited;
        r.addr  = addr;
        r.wstrb = strb;
        r.wdata = wdata;
        @(posedge clk);
        req_valid <= 1'b1;
        req       <= r;
        waited = 0;
        while (1) begin
            @(negedge clk);
            if (ready) break;
            waited++;
            if (waited > TIMEOUT) report_failure("ready never rose for the request");
        end
        @(posedge clk);
        req_valid <= 1'b0;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) shadow[{addr[31:2], 2'b00} + b] = wdata[b*8 +: 8];
        end
        lat = 0;
        do begin
            @(negedge clk);
            lat++;
            if (lat > TIMEOUT) report_failure("no response after acceptance");
        end while (!resp_valid);
        data = rdata;
    endtask

    task automatic load_check(input dcache_pkg::addr_t addr);
        dcache_pkg::word_t d;
        int                lat;
        access(addr, 4'h0, '0, d, lat);
        check_word(cur_test, shadow_word(addr), d);
    endtask

    task automatic reset_idle();
        int waited;
        cur_test = "reset";
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
            if (waited > NSET + TIMEOUT) report_failure("ready stayed low after reset");
        end while (ready !== 1'b1);
        if (waited < NSET) report_failure("ready rose before the invalidate walk could end");
        repeat (10) @(negedge clk);
        if (rd_count != 0 || wr_count != 0) report_failure("memory request while idle");
    endtask

    task automatic load_miss_hit();
        dcache_pkg::addr_t a;
        dcache_pkg::word_t d;
        int                lat;
        int                rd_before;
        cur_test  = "load_miss_hit";
        a         = make_addr(5, 3, 2);
        rd_before = rd_count;
        access(a, 4'h0, '0, d, lat);
        if (mem_rd_valid !== 1'b1) report_failure("miss response not in the refill cycle");
        if (rd_count != rd_before + 1) report_failure("miss did not issue exactly one read");
        check_addr(cur_test, {a[31:4], 4'h0}, last_rd_addr);
        check_word(cur_test, shadow_word(a), d);
        @(negedge clk);
        if (ready !== 1'b1) report_failure("ready low the cycle after the miss response");
        access(a, 4'h0, '0, d, lat);
        if (lat != 1) report_failure("load hit did not answer one cycle after acceptance");
        if (rd_count != rd_before + 1) report_failure("load hit went to memory");
        check_word(cur_test, shadow_word(a), d);
    endtask

    task automatic store_merge();
        dcache_pkg::word_t d;
        int                lat;
        cur_test = "store_hit";
        access(make_addr(5, 3, 2), 4'b0101, 32'hdead_beef, d, lat);
        if (lat != 1) report_failure("store hit did not answer one cycle after acceptance");
        if (ready !== 1'b0) report_failure("ready high in the store hit response cycle");
        load_check(make_addr(5, 3, 2));
        load_check(make_addr(5, 3, 0));
        cur_test = "store_miss";
        access(make_addr(9, 7, 1), 4'b1000, 32'h1234_5678, d, lat);
        load_check(make_addr(9, 7, 1));
        load_check(make_addr(9, 7, 3));
    endtask

    task automatic dirty_eviction();
        dcache_pkg::word_t d;
        int                lat;
        int                wr_before;
        cur_test     = "dirty_eviction";
        wb_set       = 12;
        check_wb_set = 1;
        wr_before    = wr_count;
        for (int t = 0; t <= NWAY; t++) begin
            access(make_addr(20 + t, 12, t % 4), 4'hf, $urandom, d, lat);
        end
        if (wr_count == wr_before) report_failure("no write-back after filling the set");
        for (int t = 0; t <= NWAY; t++) begin
            load_check(make_addr(20 + t, 12, t % 4));
        end
        check_wb_set = 0;
    endtask

    task automatic mixed_random();
        dcache_pkg::addr_t a;
        dcache_pkg::strb_t s;
        dcache_pkg::word_t d;
        int                lat;
        cur_test = "mixed";
        for (int i = 0; i < 300; i++) begin
            a = make_addr($urandom_range(0, 3), $urandom_range(0, 1), $urandom_range(0, 3));
            s = ($urandom_range(0, 1) == 0) ? 4'h0 : 4'($urandom_range(1, 15));
            access(a, s, $urandom, d, lat);
            if (s == 4'h0) check_word(cur_test, shadow_word(a), d);
        end
        cur_test = "final_readback";
        for (int t = 0; t < 4; t++) begin
            for (int st = 0; st < 2; st++) begin
                for (int w = 0; w < 4; w++) begin
                    load_check(make_addr(t, st, w));
                end
            end
        end
    endtask

    initial begin
        void'($urandom(32'h6c65));
        reset_idle();
        load_miss_hit();
        store_merge();
        dirty_eviction();
        mixed_random();
        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
rtl/dcache_pkg.sv
rtl/dcache_array.sv
rtl/dcache_lfsr.sv
rtl/dcache_lookup.sv
rtl/dcache_ctrl.sv
rtl/dcache_top.sv
verification/tb_clock_gen.sv
verification/dcache_assertions.sv
verification/tb_dcache.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_dcache
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
